// File: source/axi_bridge_pkg.sv
// Shared package: bus width types, AXI response codes and the AXI-lite and AXI4 channel structs
package axi_bridge_pkg;

	//////////////////////////////
	// Width types
	//////////////////////////////

	// Byte address and data word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	// One strobe bit per byte lane
	typedef logic [3:0]  strb_t;
	// Transaction ID, same width on every AXI4 channel
	typedef logic [3:0]  id_t;
	typedef logic [2:0]  prot_t;
	typedef logic [1:0]  resp_t;
	// Burst control fields of an AXI4 address channel
	typedef logic [7:0]  len_t;
	typedef logic [2:0]  size_t;
	typedef logic [1:0]  burst_t;
	typedef logic [3:0]  cache_t;
	typedef logic [3:0]  qos_t;

	//////////////////////////////
	// Constants
	//////////////////////////////

	// Response codes
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	// Four bytes per beat
	localparam size_t AXI_SIZE_WORD = 3'd2;

	//////////////////////////////
	// AXI-lite channels
	//////////////////////////////

	// Shared by AW and AR
	typedef struct packed {
		addr_t addr;
		prot_t prot;
	} axil_addr_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} axil_wdata_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} axil_rdata_t;

	//////////////////////////////
	// AXI4 channels
	//////////////////////////////

	typedef struct packed {
		id_t    id;
		addr_t  addr;
		len_t   len;
		size_t  size;
		burst_t burst;
		logic   lock;
		cache_t cache;
		prot_t  prot;
		qos_t   qos;
	} axi_addr_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} axi_wdata_t;

	typedef struct packed {
		id_t   id;
		resp_t resp;
	} axi_bresp_t;

	typedef struct packed {
		id_t   id;
		data_t data;
		resp_t resp;
		logic  last;
	} axi_rdata_t;

endpackage

// File: source/axilite_to_axi.sv
// Combinational AXI-lite to single-beat AXI4 protocol bridge
`timescale 1ns/1ps

module axilite_to_axi #(
	parameter axi_bridge_pkg::id_t C_AXI_WRITE_ID = '0,
	parameter axi_bridge_pkg::id_t C_AXI_READ_ID  = '0
) (
	// Clock and reset only mark the bridge's clock domain
	input  logic                        ACLK,
	input  logic                        i_reset,
	// AXI-lite slave side
	input  logic                        i_s_awvalid,
	output logic                        o_s_awready,
	input  axi_bridge_pkg::axil_addr_t  i_s_aw,
	input  logic                        i_s_wvalid,
	output logic                        o_s_wready,
	input  axi_bridge_pkg::axil_wdata_t i_s_w,
	output logic                        o_s_bvalid,
	input  logic                        i_s_bready,
	output axi_bridge_pkg::resp_t       o_s_bresp,
	input  logic                        i_s_arvalid,
	output logic                        o_s_arready,
	input  axi_bridge_pkg::axil_addr_t  i_s_ar,
	output logic                        o_s_rvalid,
	input  logic                        i_s_rready,
	output axi_bridge_pkg::axil_rdata_t o_s_r,
	// AXI4 master side
	output logic                        o_m_awvalid,
	input  logic                        i_m_awready,
	output axi_bridge_pkg::axi_addr_t   o_m_aw,
	output logic                        o_m_wvalid,
	input  logic                        i_m_wready,
	output axi_bridge_pkg::axi_wdata_t  o_m_w,
	input  logic                        i_m_bvalid,
	output logic                        o_m_bready,
	input  axi_bridge_pkg::axi_bresp_t  i_m_b,
	output logic                        o_m_arvalid,
	input  logic                        i_m_arready,
	output axi_bridge_pkg::axi_addr_t   o_m_ar,
	input  logic                        i_m_rvalid,
	output logic                        o_m_rready,
	input  axi_bridge_pkg::axi_rdata_t  i_m_r
);

	//////////////////////////////
	// Write address
	//////////////////////////////

	// Single beat, full word, fixed ID
	assign o_m_aw.id    = C_AXI_WRITE_ID;
	assign o_m_aw.addr  = i_s_aw.addr;
	assign o_m_aw.len   = '0;
	assign o_m_aw.size  = axi_bridge_pkg::AXI_SIZE_WORD;
	assign o_m_aw.burst = '0;
	// Normal access, no cache hints
	assign o_m_aw.lock  = 1'b0;
	assign o_m_aw.cache = '0;
	assign o_m_aw.prot  = i_s_aw.prot;
	assign o_m_aw.qos   = '0;
	assign o_m_awvalid  = i_s_awvalid;
	assign o_s_awready  = i_m_awready;

	// Write data is always the last beat
	assign o_m_w.data  = i_s_w.data;
	assign o_m_w.strb  = i_s_w.strb;
	assign o_m_w.last  = 1'b1;
	assign o_m_wvalid  = i_s_wvalid;
	assign o_s_wready  = i_m_wready;

	// Write response, ID is not passed on
	assign o_s_bresp  = i_m_b.resp;
	assign o_s_bvalid = i_m_bvalid;
	assign o_m_bready = i_s_bready;

	//////////////////////////////
	// Read address and data
	//////////////////////////////

	assign o_m_ar.id    = C_AXI_READ_ID;
	assign o_m_ar.addr  = i_s_ar.addr;
	assign o_m_ar.len   = '0;
	assign o_m_ar.size  = axi_bridge_pkg::AXI_SIZE_WORD;
	assign o_m_ar.burst = '0;
	assign o_m_ar.lock  = 1'b0;
	assign o_m_ar.cache = '0;
	assign o_m_ar.prot  = i_s_ar.prot;
	assign o_m_ar.qos   = '0;
	assign o_m_arvalid  = i_s_arvalid;
	assign o_s_arready  = i_m_arready;

	// Read return, ID and last dropped
	assign o_s_r.data = i_m_r.data;
	assign o_s_r.resp = i_m_r.resp;
	assign o_s_rvalid = i_m_rvalid;
	assign o_m_rready = i_s_rready;

endmodule

// File: source/axi_sram.sv
// AXI4 single-beat RAM slave with write/read FSM, byte strobe merge and range check
`timescale 1ns/1ps

module axi_sram #(
	parameter int MEM_WORDS = 64
) (
	input  logic                       ACLK,
	input  logic                       i_reset,
	// Write address
	input  logic                       i_awvalid,
	output logic                       o_awready,
	input  axi_bridge_pkg::axi_addr_t  i_aw,
	// Write data
	input  logic                       i_wvalid,
	output logic                       o_wready,
	input  axi_bridge_pkg::axi_wdata_t i_w,
	// Write response
	output logic                       o_bvalid,
	input  logic                       i_bready,
	output axi_bridge_pkg::axi_bresp_t o_b,
	// Read address
	input  logic                       i_arvalid,
	output logic                       o_arready,
	input  axi_bridge_pkg::axi_addr_t  i_ar,
	// Read data
	output logic                       o_rvalid,
	input  logic                       i_rready,
	output axi_bridge_pkg::axi_rdata_t o_r
);

	// Word index width, at least one bit
	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int LANES = $bits(axi_bridge_pkg::strb_t);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRESP,
		S_RDATA
	} sram_state_t;

	sram_state_t state;

	// Storage, one data word per entry
	axi_bridge_pkg::data_t mem [MEM_WORDS];

	// Accept strobes for this cycle
	logic wr_go;
	logic rd_go;
	// Address decode
	logic             wr_in_range;
	logic             rd_in_range;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	//////////////////////////////
	// Request acceptance
	//////////////////////////////

	// Write needs address and data together
	assign wr_go = (state == S_IDLE) && i_awvalid && i_wvalid;
	// Read only when no write goes this cycle
	assign rd_go = (state == S_IDLE) && i_arvalid && !wr_go;

	// Both write channels complete in the same cycle
	assign o_awready = wr_go;
	assign o_wready  = wr_go;
	assign o_arready = rd_go;

	// Responses are held while the FSM waits
	assign o_bvalid = (state == S_WRESP);
	assign o_rvalid = (state == S_RDATA);

	// Word index is the byte address over four
	assign wr_idx = i_aw.addr[IDX_W+1:2];
	assign rd_idx = i_ar.addr[IDX_W+1:2];
	// Full upper address compared, so aliasing cannot hit a valid word
	assign wr_in_range = (i_aw.addr[31:2] < 30'(MEM_WORDS));
	assign rd_in_range = (i_ar.addr[31:2] < 30'(MEM_WORDS));

	//////////////////////////////
	// State machine
	//////////////////////////////

	always_ff @(posedge ACLK)
	begin
		if (i_reset)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE:
				begin
					// Write wins over a read in the same cycle
					if (wr_go)
						state <= S_WRESP;
					else if (rd_go)
						state <= S_RDATA;
				end
				S_WRESP:
				begin
					if (i_bready)
						state <= S_IDLE;
				end
				S_RDATA:
				begin
					if (i_rready)
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Memory write
	//////////////////////////////

	// Only lanes with a strobe set are touched
	always_ff @(posedge ACLK)
	begin
		if (wr_go && wr_in_range)
		begin
			for (int i = 0; i < LANES; i++)
			begin
				if (i_w.strb[i])
					mem[wr_idx][8*i +: 8] <= i_w.data[8*i +: 8];
			end
		end
	end

	//////////////////////////////
	// Response payloads
	//////////////////////////////

	// Captured on acceptance, stable until handshake
	always_ff @(posedge ACLK)
	begin
		if (wr_go)
		begin
			o_b.id   <= i_aw.id;
			o_b.resp <= wr_in_range ? axi_bridge_pkg::RESP_OKAY
				: axi_bridge_pkg::RESP_SLVERR;
		end
		if (rd_go)
		begin
			o_r.id   <= i_ar.id;
			// Out of range reads return zero
			o_r.data <= rd_in_range ? mem[rd_idx] : '0;
			o_r.resp <= rd_in_range ? axi_bridge_pkg::RESP_OKAY
				: axi_bridge_pkg::RESP_SLVERR;
			o_r.last <= 1'b1;
		end
	end

endmodule

// File: source/axil_mem_top.sv
// Top level: AXI-lite port, AXI-lite to AXI4 bridge and AXI4 RAM slave
`timescale 1ns/1ps

module axil_mem_top #(
	parameter axi_bridge_pkg::id_t WRITE_ID  = 4'd5,
	parameter axi_bridge_pkg::id_t READ_ID   = 4'd9,
	parameter int                  MEM_WORDS = 64
) (
	input  logic                        ACLK,
	input  logic                        i_reset,
	// AXI-lite slave port
	input  logic                        i_awvalid,
	output logic                        o_awready,
	input  axi_bridge_pkg::axil_addr_t  i_aw,
	input  logic                        i_wvalid,
	output logic                        o_wready,
	input  axi_bridge_pkg::axil_wdata_t i_w,
	output logic                        o_bvalid,
	input  logic                        i_bready,
	output axi_bridge_pkg::resp_t       o_bresp,
	input  logic                        i_arvalid,
	output logic                        o_arready,
	input  axi_bridge_pkg::axil_addr_t  i_ar,
	output logic                        o_rvalid,
	input  logic                        i_rready,
	output axi_bridge_pkg::axil_rdata_t o_r
);

	//////////////////////////////
	// Internal AXI4 bus
	//////////////////////////////

	logic                       m_awvalid;
	logic                       m_awready;
	axi_bridge_pkg::axi_addr_t  m_aw;
	logic                       m_wvalid;
	logic                       m_wready;
	axi_bridge_pkg::axi_wdata_t m_w;
	logic                       m_bvalid;
	logic                       m_bready;
	axi_bridge_pkg::axi_bresp_t m_b;
	logic                       m_arvalid;
	logic                       m_arready;
	axi_bridge_pkg::axi_addr_t  m_ar;
	logic                       m_rvalid;
	logic                       m_rready;
	axi_bridge_pkg::axi_rdata_t m_r;

	// Protocol conversion, zero latency
	axilite_to_axi #(
		.C_AXI_WRITE_ID(WRITE_ID),
		.C_AXI_READ_ID (READ_ID)
	) u_bridge (
		.ACLK       (ACLK),
		.i_reset    (i_reset),
		.i_s_awvalid(i_awvalid),
		.o_s_awready(o_awready),
		.i_s_aw     (i_aw),
		.i_s_wvalid (i_wvalid),
		.o_s_wready (o_wready),
		.i_s_w      (i_w),
		.o_s_bvalid (o_bvalid),
		.i_s_bready (i_bready),
		.o_s_bresp  (o_bresp),
		.i_s_arvalid(i_arvalid),
		.o_s_arready(o_arready),
		.i_s_ar     (i_ar),
		.o_s_rvalid (o_rvalid),
		.i_s_rready (i_rready),
		.o_s_r      (o_r),
		.o_m_awvalid(m_awvalid),
		.i_m_awready(m_awready),
		.o_m_aw     (m_aw),
		.o_m_wvalid (m_wvalid),
		.i_m_wready (m_wready),
		.o_m_w      (m_w),
		.i_m_bvalid (m_bvalid),
		.o_m_bready (m_bready),
		.i_m_b      (m_b),
		.o_m_arvalid(m_arvalid),
		.i_m_arready(m_arready),
		.o_m_ar     (m_ar),
		.i_m_rvalid (m_rvalid),
		.o_m_rready (m_rready),
		.i_m_r      (m_r)
	);

	// Word RAM behind the bridge
	axi_sram #(
		.MEM_WORDS(MEM_WORDS)
	) u_sram (
		.ACLK     (ACLK),
		.i_reset  (i_reset),
		.i_awvalid(m_awvalid),
		.o_awready(m_awready),
		.i_aw     (m_aw),
		.i_wvalid (m_wvalid),
		.o_wready (m_wready),
		.i_w      (m_w),
		.o_bvalid (m_bvalid),
		.i_bready (m_bready),
		.o_b      (m_b),
		.i_arvalid(m_arvalid),
		.o_arready(m_arready),
		.i_ar     (m_ar),
		.o_rvalid (m_rvalid),
		.i_rready (m_rready),
		.o_r      (m_r)
	);

endmodule

// File: verif/axil_mem_chk.sv
// Bound assertions on the bridge: response stability and response IDs
`timescale 1ns/1ps

module axil_mem_chk #(
	parameter axi_bridge_pkg::id_t WRITE_ID = '0,
	parameter axi_bridge_pkg::id_t READ_ID  = '0
) (
	input logic                       ACLK,
	input logic                       i_reset,
	// AXI4 responses coming back
	input logic                       i_bvalid,
	input logic                       i_bready,
	input axi_bridge_pkg::axi_bresp_t i_b,
	input logic                       i_rvalid,
	input logic                       i_rready,
	input axi_bridge_pkg::axi_rdata_t i_r
);

	// Read at the end of the run by the testbench
	int fail_count = 0;

	//////////////////////////////
	// Response stability
	//////////////////////////////

	// Response held steady under back-pressure
	a_b_stable: assert property (@(posedge ACLK) disable iff (i_reset)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_b)))
		else
		begin
			$error("B channel changed while bready low");
			fail_count++;
		end

	a_r_stable: assert property (@(posedge ACLK) disable iff (i_reset)
		(i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_r)))
		else
		begin
			$error("R channel changed while rready low");
			fail_count++;
		end

	//////////////////////////////
	// Returned IDs
	//////////////////////////////

	a_b_id: assert property (@(posedge ACLK) disable iff (i_reset)
		i_bvalid |-> i_b.id == WRITE_ID)
		else
		begin
			$error("B ID differs from the write ID");
			fail_count++;
		end

	a_r_id: assert property (@(posedge ACLK) disable iff (i_reset)
		i_rvalid |-> i_r.id == READ_ID)
		else
		begin
			$error("R ID differs from the read ID");
			fail_count++;
		end

endmodule

// Attach to every bridge, on its AXI4 side
bind axilite_to_axi axil_mem_chk #(
	.WRITE_ID(C_AXI_WRITE_ID),
	.READ_ID (C_AXI_READ_ID)
) u_chk (
	.ACLK     (ACLK),
	.i_reset  (i_reset),
	.i_bvalid (i_m_bvalid),
	.i_bready (o_m_bready),
	.i_b      (i_m_b),
	.i_rvalid (i_m_rvalid),
	.i_rready (o_m_rready),
	.i_r      (i_m_r)
);

// File: verif/axil_mem_tb.sv
// Directed testbench for the AXI-lite memory: clock, reset, watchdog, word model and tests
`timescale 1ns/1ps

module axil_mem_tb;

	localparam int CLK_PERIOD = 40;
	localparam int MEM_WORDS  = 64;
	// Transactions per test: full word, strobes, range, back-pressure, random
	localparam int TRANS_TOTAL     = 8 + 10 + 5 + 8 + 100;
	localparam int WATCHDOG_CYCLES = TRANS_TOTAL * 20 + 40;

	logic                        ACLK;
	logic                        i_reset;
	logic                        i_awvalid;
	logic                        o_awready;
	axi_bridge_pkg::axil_addr_t  i_aw;
	logic                        i_wvalid;
	logic                        o_wready;
	axi_bridge_pkg::axil_wdata_t i_w;
	logic                        o_bvalid;
	logic                        i_bready;
	axi_bridge_pkg::resp_t       o_bresp;
	logic                        i_arvalid;
	logic                        o_arready;
	axi_bridge_pkg::axil_addr_t  i_ar;
	logic                        o_rvalid;
	logic                        i_rready;
	axi_bridge_pkg::axil_rdata_t o_r;

	// Word model and the byte lanes written so far
	axi_bridge_pkg::data_t model_mem [MEM_WORDS];
	axi_bridge_pkg::strb_t model_known [MEM_WORDS];

	logic [31:0] rng = 32'd61;
	string       cur_test;
	int          errors = 0;
	int          err_mark;
	int          tests_passed = 0;
	int          tests_failed = 0;

	axil_mem_top #(
		.WRITE_ID (4'd5),
		.READ_ID  (4'd9),
		.MEM_WORDS(MEM_WORDS)
	) UUT (
		.ACLK(ACLK), .i_reset(i_reset),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_aw(i_aw),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_w(i_w),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_ar(i_ar),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_r(o_r)
	);

	always #(CLK_PERIOD / 2) ACLK = ~ACLK;

	//////////////////////////////
	// Model and reporting
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One byte of mask per strobe bit
	function automatic logic [31:0] lane_mask(input axi_bridge_pkg::strb_t strb);
		logic [31:0] m;
		for (int i = 0; i < 4; i++)
			m[8*i +: 8] = {8{strb[i]}};
		return m;
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic end_test();
		if (errors == err_mark)
		begin
			tests_passed++;
			$display("Test %s finished, no errors", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("Test %s finished with %0d errors", cur_test, errors - err_mark);
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("** Error %s: %s expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_fail(input string msg);
		$display("Failure in %s: %s", cur_test, msg);
		errors++;
	endtask

	// Write and read side of the model, range rule included
	task automatic expect_write(input int idx, input axi_bridge_pkg::data_t data,
		input axi_bridge_pkg::strb_t strb, input axi_bridge_pkg::resp_t resp);
		logic [31:0] m;
		m = lane_mask(strb);
		if (idx < MEM_WORDS)
		begin
			compare_value("write resp", axi_bridge_pkg::RESP_OKAY, resp);
			model_mem[idx] = (model_mem[idx] & ~m) | (data & m);
			model_known[idx] = model_known[idx] | strb;
		end
		else
			compare_value("write resp", axi_bridge_pkg::RESP_SLVERR, resp);
	endtask

	task automatic expect_read(input int idx, input axi_bridge_pkg::data_t data,
		input axi_bridge_pkg::resp_t resp);
		logic [31:0] m;
		if (idx < MEM_WORDS)
		begin
			m = lane_mask(model_known[idx]);
			compare_value("read resp", axi_bridge_pkg::RESP_OKAY, resp);
			// Bytes never written are undefined
			compare_value("read data", model_mem[idx] & m, data & m);
		end
		else
		begin
			compare_value("read resp", axi_bridge_pkg::RESP_SLVERR, resp);
			compare_value("read data", 32'h0, data);
		end
	endtask

	//////////////////////////////
	// Bus helpers
	//////////////////////////////

	// Write with stall cycles of B ready low; a read is offered during the stall
	task automatic axil_write(input axi_bridge_pkg::addr_t addr, input axi_bridge_pkg::data_t data,
		input axi_bridge_pkg::strb_t strb, input int stall, output axi_bridge_pkg::resp_t resp);
		@(posedge ACLK);
		i_awvalid <= 1'b1;
		i_aw.addr <= addr;
		i_wvalid <= 1'b1;
		i_w.data <= data;
		i_w.strb <= strb;
		@(negedge ACLK);
		if (!(o_awready && o_wready))
			report_fail("AW and W ready did not rise in the request cycle");
		while (!(o_awready && o_wready))
			@(negedge ACLK);
		// Accepted on this edge
		@(posedge ACLK);
		i_awvalid <= 1'b0;
		i_wvalid <= 1'b0;
		i_bready <= (stall == 0);
		@(negedge ACLK);
		if (o_bvalid !== 1'b1)
			report_fail("B valid did not rise one cycle after the write was accepted");
		while (o_bvalid !== 1'b1)
			@(negedge ACLK);
		resp = o_bresp;
		for (int n = 0; n < stall; n++)
		begin
			@(posedge ACLK);
			i_arvalid <= 1'b1;
			i_bready <= (n == stall - 1);
			@(negedge ACLK);
			if (o_bvalid !== 1'b1 || o_bresp !== resp)
				report_fail("B valid or response changed while B ready was low");
			if (o_arready !== 1'b0)
				report_fail("read accepted while a write response was pending");
		end
		// B handshake edge
		@(posedge ACLK);
		i_bready <= 1'b0;
		i_arvalid <= 1'b0;
	endtask

	// Read with stall cycles of R ready low; a strobe-less write is offered during the stall
	task automatic axil_read(input axi_bridge_pkg::addr_t addr, input int stall,
		output axi_bridge_pkg::data_t data, output axi_bridge_pkg::resp_t resp);
		@(posedge ACLK);
		i_arvalid <= 1'b1;
		i_ar.addr <= addr;
		@(negedge ACLK);
		if (o_arready !== 1'b1)
			report_fail("AR ready did not rise in the request cycle");
		while (o_arready !== 1'b1)
			@(negedge ACLK);
		@(posedge ACLK);
		i_arvalid <= 1'b0;
		i_rready <= (stall == 0);
		@(negedge ACLK);
		if (o_rvalid !== 1'b1)
			report_fail("R valid did not rise one cycle after the read was accepted");
		while (o_rvalid !== 1'b1)
			@(negedge ACLK);
		data = o_r.data;
		resp = o_r.resp;
		for (int n = 0; n < stall; n++)
		begin
			@(posedge ACLK);
			i_awvalid <= 1'b1;
			i_wvalid <= 1'b1;
			i_w.strb <= '0;
			i_rready <= (n == stall - 1);
			@(negedge ACLK);
			if (o_rvalid !== 1'b1 || o_r.data !== data || o_r.resp !== resp)
				report_fail("R valid or payload changed while R ready was low");
			if (o_awready !== 1'b0 || o_wready !== 1'b0)
				report_fail("write accepted while read data was pending");
		end
		@(posedge ACLK);
		i_rready <= 1'b0;
		i_awvalid <= 1'b0;
		i_wvalid <= 1'b0;
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset();
		start_test("reset");
		// Outputs checked while reset is high, then just after release
		for (int c = 0; c < 17; c++)
		begin
			@(negedge ACLK);
			if ({o_awready, o_wready, o_arready, o_bvalid, o_rvalid} !== 5'b0)
				report_fail("a ready or valid output is not low around reset");
			if (c == 14)
			begin
				@(posedge ACLK);
				i_reset <= 1'b0;
			end
		end
		end_test();
	endtask

	task automatic test_full_word();
		axi_bridge_pkg::resp_t resp;
		axi_bridge_pkg::data_t data;
		start_test("full_word");
		for (int i = 0; i < 4; i++)
		begin
			rng = xorshift32(rng);
			axil_write(32'(i * 4), rng, 4'hF, 0, resp);
			expect_write(i, rng, 4'hF, resp);
		end
		for (int i = 0; i < 4; i++)
		begin
			axil_read(32'(i * 4), 0, data, resp);
			expect_read(i, data, resp);
		end
		end_test();
	endtask

	task automatic test_byte_strobes();
		axi_bridge_pkg::strb_t strbs [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
		axi_bridge_pkg::resp_t resp;
		axi_bridge_pkg::data_t data;
		start_test("byte_strobes");
		axil_write(32'd40, 32'h1122_3344, 4'hF, 0, resp);
		expect_write(10, 32'h1122_3344, 4'hF, resp);
		axil_read(32'd40, 0, data, resp);
		expect_read(10, data, resp);
		for (int i = 0; i < 4; i++)
		begin
			rng = xorshift32(rng);
			axil_write(32'd40, rng, strbs[i], 0, resp);
			expect_write(10, rng, strbs[i], resp);
			axil_read(32'd40, 0, data, resp);
			expect_read(10, data, resp);
		end
		end_test();
	endtask

	task automatic test_out_of_range();
		axi_bridge_pkg::resp_t resp;
		axi_bridge_pkg::data_t data;
		start_test("out_of_range");
		axil_write(32'd0, 32'hA5A5_5A5A, 4'hF, 0, resp);
		expect_write(0, 32'hA5A5_5A5A, 4'hF, resp);
		// Word 64 shares its low index bits with word 0
		axil_write(32'h100, 32'hDEAD_BEEF, 4'hF, 0, resp);
		expect_write(64, 32'hDEAD_BEEF, 4'hF, resp);
		axil_read(32'h100, 0, data, resp);
		expect_read(64, data, resp);
		axil_read(32'h8000_0000, 0, data, resp);
		expect_read(MEM_WORDS + 1, data, resp);
		axil_read(32'd0, 0, data, resp);
		expect_read(0, data, resp);
		end_test();
	endtask

	task automatic test_back_pressure();
		axi_bridge_pkg::resp_t resp;
		axi_bridge_pkg::data_t data;
		int                    idx;
		start_test("back_pressure");
		for (int i = 0; i < 4; i++)
		begin
			idx = 20 + i;
			rng = xorshift32(rng);
			data = rng;
			rng = xorshift32(rng);
			axil_write(32'(idx * 4), data, 4'hF, 1 + int'(rng % 6), resp);
			expect_write(idx, data, 4'hF, resp);
			rng = xorshift32(rng);
			axil_read(32'(idx * 4), 1 + int'(rng % 6), data, resp);
			expect_read(idx, data, resp);
		end
		end_test();
	endtask

	task automatic test_random_mix();
		axi_bridge_pkg::resp_t resp;
		axi_bridge_pkg::data_t data;
		axi_bridge_pkg::strb_t strb;
		int                    idx;
		int                    stall;
		start_test("random_mix");
		for (int i = 0; i < 100; i++)
		begin
			rng = xorshift32(rng);
			idx = int'(rng % MEM_WORDS);
			stall = int'(rng[9:8]);
			strb = rng[15:12];
			if (rng[20])
			begin
				rng = xorshift32(rng);
				axil_write(32'(idx * 4), rng, strb, stall, resp);
				expect_write(idx, rng, strb, resp);
			end
			else
			begin
				axil_read(32'(idx * 4), stall, data, resp);
				expect_read(idx, data, resp);
			end
		end
		end_test();
	endtask

	//////////////////////////////
	// Run control
	//////////////////////////////

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		ACLK = 1'b0;
		i_reset = 1'b1;
		i_awvalid = 1'b0;
		i_aw = '0;
		i_wvalid = 1'b0;
		i_w = '0;
		i_bready = 1'b0;
		i_arvalid = 1'b0;
		i_ar = '0;
		i_rready = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			model_mem[i] = '0;
			model_known[i] = '0;
		end
		test_reset();
		test_full_word();
		test_byte_strobes();
		test_out_of_range();
		test_back_pressure();
		test_random_mix();
		errors = errors + UUT.u_bridge.u_chk.fail_count;
		$display("Tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
			tests_passed, tests_failed, errors, UUT.u_bridge.u_chk.fail_count);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: project.f
source/axi_bridge_pkg.sv
source/axilite_to_axi.sv
source/axi_sram.sv
source/axil_mem_top.sv
verif/axil_mem_chk.sv
verif/axil_mem_tb.sv
